// File: memTypesPkg.sv
// Memory bus types
`default_nettype none

package memTypesPkg;

  // Main memory holds 512 words of 32 bits
  localparam int MemWords = 512;
  localparam int MemAddrBits = $clog2(MemWords) + 2;

  // Cycles from a granted request to the ready pulse
  localparam int MemLatency = 2;
  localparam int LatencyBits = $clog2(MemLatency + 1);

  // Request from a cache port towards memory
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        read;
    logic        write;
  } memReqT;

  // Reply from memory, routed to the granted port
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } memRspT;

endpackage

`default_nettype wire

// File: cacheTypesPkg.sv
// Cache and CPU types
`default_nettype none

package cacheTypesPkg;

  // Direct-mapped, one word per line
  localparam int LineCount = 32;
  localparam int IndexBits = 5;
  localparam int TagBits = 4;

  typedef enum logic [1:0] {
    sizeByte = 2'd0,
    sizeHalf = 2'd1,
    sizeWord = 2'd2
  } accessSizeE;

  // Level request from the CPU side
  typedef struct packed {
    logic [31:0] address;
    logic [31:0] dataIn;
    logic        readEnable;
    logic        writeEnable;
    accessSizeE  size;
    logic        unsignedRead;
  } cpuReqT;

  typedef enum logic [1:0] {
    stIdle  = 2'd0,
    stRead  = 2'd1,
    stWrite = 2'd2,
    stReady = 2'd3
  } cacheStateE;

endpackage

`default_nettype wire

// File: loadFormatter.sv
// Load data alignment and extension
`default_nettype none

module loadFormatter
  import cacheTypesPkg::*;
(
  input  wire logic [63:0] window,
  input  wire logic [1:0]  offset,
  input  wire accessSizeE  size,
  input  wire logic        unsignedRead,
  output logic [31:0]      dataOut
);

  logic [63:0] shifted;
  logic [7:0]  byteVal;
  logic [15:0] halfVal;
  logic        byteSign;
  logic        halfSign;

  // Bring the addressed byte down to bit 0
  assign shifted = window >> {offset, 3'b000};

  assign byteVal = shifted[7:0];
  assign halfVal = shifted[15:0];

  // Sign bits are masked off for unsigned loads
  assign byteSign = byteVal[7] & ~unsignedRead;
  assign halfSign = halfVal[15] & ~unsignedRead;

  always_comb begin
    unique case (size)
      sizeByte: begin
        dataOut = {{24{byteSign}}, byteVal};
      end
      sizeHalf: begin
        dataOut = {{16{halfSign}}, halfVal};
      end
      sizeWord: begin
        dataOut = shifted[31:0];
      end
      default: begin
        dataOut = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: cacheL1.sv
// Write-through L1 cache
`default_nettype none

module cacheL1
  import memTypesPkg::*;
  import cacheTypesPkg::*;
(
  input  wire         clk,
  input  wire         rstN,
  input  wire cpuReqT cpuReq,
  output logic [31:0] dataOut,
  output logic        cacheReady,
  output logic        accessFault,
  output memReqT      memReq,
  input  wire memRspT memRsp,
  input  wire memReqT snoop,
  input  wire         snoopValid
);

  logic                lineValid [LineCount];
  logic [TagBits-1:0]  lineTag [LineCount];
  logic [31:0]         lineData [LineCount];

  cacheStateE state;
  logic       fetchNext;
  logic [31:0] savedAddr;

  logic        anyReq;
  logic        fault;
  logic        needNext;
  logic        addrChanged;
  logic        readHit;
  logic        hit0;
  logic        hit1;
  logic        writeTagMatch;
  logic        snoopHit;
  logic [31:0] nextAddr;
  logic [31:0] reqAddr;
  logic [31:0] formatted;

  logic [IndexBits-1:0] idx0;
  logic [IndexBits-1:0] idx1;
  logic [IndexBits-1:0] fillIdx;
  logic [IndexBits-1:0] snoopIdx;
  logic [TagBits-1:0]   tag0;
  logic [TagBits-1:0]   tag1;
  logic [TagBits-1:0]   fillTag;
  logic [TagBits-1:0]   snoopTag;

  assign anyReq = cpuReq.readEnable | cpuReq.writeEnable;
  assign fault = anyReq & (|cpuReq.address[31:MemAddrBits]);

  // Loads that straddle a word boundary need the following word too
  assign needNext = ((cpuReq.size == sizeWord) && (cpuReq.address[1:0] != 2'b00)) ||
                    ((cpuReq.size == sizeHalf) && (cpuReq.address[1:0] == 2'b11));
  assign nextAddr = cpuReq.address + 32'd4;

  assign idx0 = cpuReq.address[IndexBits+1:2];
  assign tag0 = cpuReq.address[IndexBits+2 +: TagBits];
  assign idx1 = nextAddr[IndexBits+1:2];
  assign tag1 = nextAddr[IndexBits+2 +: TagBits];

  assign hit0 = lineValid[idx0] && (lineTag[idx0] == tag0);
  assign hit1 = lineValid[idx1] && (lineTag[idx1] == tag1);
  assign writeTagMatch = lineTag[idx0] == tag0;
  assign readHit = cpuReq.readEnable && !fault && hit0 && (!needNext || hit1);

  // A new address while busy abandons the transaction
  assign addrChanged = (state != stIdle) && (cpuReq.address != savedAddr);

  assign reqAddr = fetchNext ? nextAddr : cpuReq.address;
  assign fillIdx = reqAddr[IndexBits+1:2];
  assign fillTag = reqAddr[IndexBits+2 +: TagBits];

  assign snoopIdx = snoop.addr[IndexBits+1:2];
  assign snoopTag = snoop.addr[IndexBits+2 +: TagBits];
  assign snoopHit = snoopValid && lineValid[snoopIdx] && (lineTag[snoopIdx] == snoopTag);

  always_comb begin
    memReq = '0;
    memReq.addr = reqAddr;
    memReq.wdata = cpuReq.dataIn;
    memReq.read = (state == stRead) && !addrChanged;
    memReq.write = (state == stWrite) && !addrChanged;
  end

  loadFormatter uFormatter (
    .window      ({lineData[idx1], lineData[idx0]}),
    .offset      (cpuReq.address[1:0]),
    .size        (cpuReq.size),
    .unsignedRead(cpuReq.unsignedRead),
    .dataOut     (formatted)
  );

  assign accessFault = fault;
  assign dataOut = fault ? 32'd0 : formatted;
  assign cacheReady = ((state == stIdle) && (!anyReq || fault || readHit)) ||
                      ((state == stReady) && !addrChanged);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= stIdle;
      fetchNext <= 1'b0;
      savedAddr <= '0;
      for (int i = 0; i < LineCount; i++) begin
        lineValid[i] <= 1'b0;
      end
    end else begin
      // Other port wrote this word
      if (snoopHit) begin
        lineValid[snoopIdx] <= 1'b0;
      end
      if (addrChanged) begin
        state <= stIdle;
        fetchNext <= 1'b0;
      end else begin
        unique case (state)
          stIdle: begin
            savedAddr <= cpuReq.address;
            fetchNext <= 1'b0;
            if (!fault && cpuReq.readEnable && !readHit) begin
              state <= stRead;
            end else if (!fault && !cpuReq.readEnable && cpuReq.writeEnable) begin
              state <= stWrite;
            end
          end
          stRead: begin
            if (memRsp.ready) begin
              lineValid[fillIdx] <= 1'b1;
              if (needNext && !fetchNext) begin
                fetchNext <= 1'b1;
              end else begin
                fetchNext <= 1'b0;
                state <= stReady;
              end
            end
          end
          stWrite: begin
            if (memRsp.ready) begin
              if (writeTagMatch) begin
                lineValid[idx0] <= 1'b0;
              end
              state <= stReady;
            end
          end
          stReady: begin
            state <= stIdle;
          end
          default: begin
            state <= stIdle;
          end
        endcase
      end
    end
  end

  // Fill path
  always_ff @(posedge clk) begin
    if ((state == stRead) && !addrChanged && memRsp.ready) begin
      lineData[fillIdx] <= memRsp.rdata;
      lineTag[fillIdx] <= fillTag;
    end
  end

endmodule

`default_nettype wire

// File: memArbiter.sv
// Round-robin memory bus arbiter
`default_nettype none

module memArbiter
  import memTypesPkg::*;
(
  input  wire         clk,
  input  wire         rstN,
  input  wire memReqT req0,
  input  wire memReqT req1,
  output memRspT      rsp0,
  output memRspT      rsp1,
  output memReqT      memReq,
  input  wire memRspT memRsp,
  output memReqT      snoop0,
  output memReqT      snoop1,
  output logic        snoopValid0,
  output logic        snoopValid1
);

  logic active0;
  logic active1;
  logic prio;
  logic owner;
  logic locked;
  logic sel;
  logic selActive;

  assign active0 = req0.read | req0.write;
  assign active1 = req1.read | req1.write;

  // Held grant wins, otherwise the preferred port unless it is quiet
  always_comb begin
    if (locked) begin
      sel = owner;
    end else if (prio) begin
      sel = active1 | ~active0;
    end else begin
      sel = active1 & ~active0;
    end
  end

  assign selActive = sel ? active1 : active0;
  assign memReq = sel ? req1 : req0;

  always_comb begin
    rsp0.rdata = sel ? 32'd0 : memRsp.rdata;
    rsp0.ready = memRsp.ready & ~sel;
    rsp1.rdata = sel ? memRsp.rdata : 32'd0;
    rsp1.ready = memRsp.ready & sel;
  end

  // Each cache watches writes from the other port
  assign snoop0 = memReq;
  assign snoop1 = memReq;
  assign snoopValid0 = memRsp.ready & memReq.write & sel;
  assign snoopValid1 = memRsp.ready & memReq.write & ~sel;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      prio <= 1'b0;
      owner <= 1'b0;
      locked <= 1'b0;
    end else if (memRsp.ready) begin
      locked <= 1'b0;
      prio <= ~sel;
    end else if (selActive) begin
      locked <= 1'b1;
      owner <= sel;
    end else begin
      locked <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: mainMemory.sv
// Fixed-latency main memory
`default_nettype none

module mainMemory
  import memTypesPkg::*;
(
  input  wire         clk,
  input  wire         rstN,
  input  wire memReqT memReq,
  output memRspT      memRsp
);

  logic [31:0] mem [MemWords];

  logic [LatencyBits-1:0] latCnt;
  logic [MemAddrBits-3:0] wordIdx;
  logic                   active;
  logic                   fire;

  assign active = memReq.read | memReq.write;
  assign wordIdx = memReq.addr[MemAddrBits-1:2];

  // Ready arrives MemLatency cycles after the request first shows up
  assign fire = active && (latCnt == LatencyBits'(MemLatency));

  always_comb begin
    memRsp.ready = fire;
    memRsp.rdata = (fire && memReq.read) ? mem[wordIdx] : 32'd0;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      latCnt <= '0;
    end else if (!active || fire) begin
      latCnt <= '0;
    end else begin
      latCnt <= latCnt + 1'b1;
    end
  end

  // Contents start out cleared
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < MemWords; i++) begin
        mem[i] <= 32'd0;
      end
    end else if (fire && memReq.write) begin
      mem[wordIdx] <= memReq.wdata;
    end
  end

endmodule

`default_nettype wire

// File: memSubsystem.sv
// Two-port cached memory subsystem
`default_nettype none

module memSubsystem
  import memTypesPkg::*;
  import cacheTypesPkg::*;
(
  input  wire         clk,
  input  wire         rstN,
  input  wire cpuReqT cpuReq0,
  input  wire cpuReqT cpuReq1,
  output logic [31:0] dataOut0,
  output logic [31:0] dataOut1,
  output logic        cacheReady0,
  output logic        cacheReady1,
  output logic        accessFault0,
  output logic        accessFault1
);

  memReqT cacheReq0;
  memReqT cacheReq1;
  memRspT cacheRsp0;
  memRspT cacheRsp1;
  memReqT busReq;
  memRspT busRsp;
  memReqT snoop0;
  memReqT snoop1;
  logic   snoopValid0;
  logic   snoopValid1;

  cacheL1 uCache0 (
    .clk        (clk),
    .rstN       (rstN),
    .cpuReq     (cpuReq0),
    .dataOut    (dataOut0),
    .cacheReady (cacheReady0),
    .accessFault(accessFault0),
    .memReq     (cacheReq0),
    .memRsp     (cacheRsp0),
    .snoop      (snoop0),
    .snoopValid (snoopValid0)
  );

  cacheL1 uCache1 (
    .clk        (clk),
    .rstN       (rstN),
    .cpuReq     (cpuReq1),
    .dataOut    (dataOut1),
    .cacheReady (cacheReady1),
    .accessFault(accessFault1),
    .memReq     (cacheReq1),
    .memRsp     (cacheRsp1),
    .snoop      (snoop1),
    .snoopValid (snoopValid1)
  );

  memArbiter uArbiter (
    .clk        (clk),
    .rstN       (rstN),
    .req0       (cacheReq0),
    .req1       (cacheReq1),
    .rsp0       (cacheRsp0),
    .rsp1       (cacheRsp1),
    .memReq     (busReq),
    .memRsp     (busRsp),
    .snoop0     (snoop0),
    .snoop1     (snoop1),
    .snoopValid0(snoopValid0),
    .snoopValid1(snoopValid1)
  );

  mainMemory uMemory (
    .clk   (clk),
    .rstN  (rstN),
    .memReq(busReq),
    .memRsp(busRsp)
  );

endmodule

`default_nettype wire

// File: memSubsystem_checker.sv
// Bus and ready assertions
`default_nettype none

module memSubsystem_checker
  import memTypesPkg::*;
  import cacheTypesPkg::*;
(
  input wire logic       clk,
  input wire logic       rstN,
  input wire memReqT     busReq,
  input wire memRspT     busRsp,
  input wire logic       snoopValid0,
  input wire logic       snoopValid1,
  input wire cacheStateE state0,
  input wire cacheStateE state1,
  input wire logic       cacheReady0,
  input wire logic       cacheReady1
);
  timeunit 1ns;
  timeprecision 100ps;

  int assertFails = 0;

  readWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(busReq.read && busReq.write))
    else begin
      assertFails++;
      $error("memory read and write are both high");
    end

  // Granted request holds until memory answers
  grantStable: assert property (@(posedge clk) disable iff (!rstN)
    (busReq.read || busReq.write) && !busRsp.ready |=> $stable(busReq))
    else begin
      assertFails++;
      $error("granted memory request changed before ready");
    end

  snoopOnWrite: assert property (@(posedge clk) disable iff (!rstN)
    (snoopValid0 || snoopValid1) |-> busRsp.ready && busReq.write && !(snoopValid0 && snoopValid1))
    else begin
      assertFails++;
      $error("snoop pulse without a completing write");
    end

  noReadyWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
    (((state0 == stRead) || (state0 == stWrite)) -> !cacheReady0) &&
    (((state1 == stRead) || (state1 == stWrite)) -> !cacheReady1))
    else begin
      assertFails++;
      $error("cacheReady high while a cache waits on memory");
    end

endmodule

`default_nettype wire

// File: tbMemSubsystem.sv
// Two-port memory subsystem testbench
`default_nettype none

module tbMemSubsystem
  import memTypesPkg::*;
  import cacheTypesPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AccessCount = 300;
  localparam int TimeoutCycles = 2 * AccessCount * (2 * (MemLatency + 2) * 2 + 4);
  localparam int SpaceBytes = 2048;

  logic             clk;
  logic             rstN;
  cpuReqT [1:0]     portReq;
  logic [1:0][31:0] dataOut;
  logic [1:0]       ready;
  logic [1:0]       fault;
  logic [1:0]       busy;

  // Byte-wide reference of the 2 KB space
  logic [7:0]  refMem [SpaceBytes];
  logic [31:0] lastAddr [2];
  int          issued [2];
  int          wordLo [2];
  int          wordHi [2];
  int          errorCount;
  int          checkCount;
  int          cycleCount;

  memSubsystem DUT (
    .clk         (clk),
    .rstN        (rstN),
    .cpuReq0     (portReq[0]),
    .cpuReq1     (portReq[1]),
    .dataOut0    (dataOut[0]),
    .dataOut1    (dataOut[1]),
    .cacheReady0 (ready[0]),
    .cacheReady1 (ready[1]),
    .accessFault0(fault[0]),
    .accessFault1(fault[1])
  );

  bind memSubsystem memSubsystem_checker uChecker (
    .clk        (clk),
    .rstN       (rstN),
    .busReq     (busReq),
    .busRsp     (busRsp),
    .snoopValid0(snoopValid0),
    .snoopValid1(snoopValid1),
    .state0     (uCache0.state),
    .state1     (uCache1.state),
    .cacheReady0(cacheReady0),
    .cacheReady1(cacheReady1)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("ERROR: run hung, accesses still pending after %0d cycles", cycleCount);
      $display("%0d checks, %0d errors", checkCount, errorCount);
      $display("sim failed");
      $finish;
    end
  end

  function automatic int sizeBytes(accessSizeE size);
    case (size)
      sizeByte: return 1;
      sizeHalf: return 2;
      default: return 4;
    endcase
  endfunction

  // Little-endian gather, then extend from the top loaded bit
  function automatic logic [31:0] expectedLoad(cpuReqT r);
    logic [31:0] raw;
    int n;
    int i;
    raw = '0;
    n = sizeBytes(r.size);
    for (i = 0; i < n; i++) begin
      raw[8*i +: 8] = refMem[int'(r.address) + i];
    end
    if (!r.unsignedRead && (n < 4) && raw[8*n-1]) begin
      raw = raw | ~((32'd1 << (8 * n)) - 32'd1);
    end
    return raw;
  endfunction

  task automatic storeWord(logic [31:0] addr, logic [31:0] data);
    int base;
    int i;
    base = int'({addr[31:2], 2'b00});
    for (i = 0; i < 4; i++) begin
      refMem[base + i] = data[8*i +: 8];
    end
  endtask

  task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // New random access kept off the words the other port is using
  task automatic issueAccess(int p);
    cpuReqT r;
    int roll;
    int lo;
    int hi;
    logic placed;
    placed = 1'b0;
    r = '0;
    lo = -1;
    hi = -1;
    while (!placed) begin
      roll = int'($urandom % 100);
      r = '0;
      r.size = accessSizeE'($urandom % 3);
      r.unsignedRead = 1'($urandom);
      r.dataIn = $urandom;
      if (1'($urandom)) begin
        r.readEnable = 1'b1;
      end else begin
        r.writeEnable = 1'b1;
      end
      if (roll < 5) begin
        // Out of range with low bits aliasing into the busy window
        r.address = (32'd1 << (11 + $urandom % 21)) | ($urandom & 32'hffff_f800) |
                    (32'h100 + $urandom % 256);
      end else if (roll < 20) begin
        r.address = lastAddr[p];
      end else if (roll < 30) begin
        r.address = lastAddr[1-p];
      end else if (roll < 85) begin
        r.address = 32'h100 + $urandom % 256;
      end else begin
        r.address = $urandom % (SpaceBytes - 3);
      end
      lo = -1;
      hi = -1;
      if (r.address < SpaceBytes) begin
        lo = int'(r.address >> 2);
        hi = r.readEnable ? int'((r.address + sizeBytes(r.size) - 1) >> 2) : lo;
      end
      placed = !busy[1-p] || (lo < 0) || (wordLo[1-p] < 0) ||
               (hi < wordLo[1-p]) || (lo > wordHi[1-p]);
    end
    portReq[p] = r;
    wordLo[p] = lo;
    wordHi[p] = hi;
    busy[p] = 1'b1;
    issued[p]++;
  endtask

  task automatic completeAccess(int p);
    cpuReqT r;
    string name;
    r = portReq[p];
    name = $sformatf("port%0d access %0d at %h", p, issued[p], r.address);
    if (r.address >= SpaceBytes) begin
      checkValue({name, " fault flag"}, 32'd1, 32'(fault[p]));
      checkValue({name, " fault data"}, 32'd0, dataOut[p]);
    end else begin
      checkValue({name, " fault flag"}, 32'd0, 32'(fault[p]));
      if (r.readEnable) begin
        checkValue({name, " load"}, expectedLoad(r), dataOut[p]);
      end else begin
        storeWord(r.address, r.dataIn);
      end
      lastAddr[p] = r.address;
    end
    busy[p] = 1'b0;
  endtask

  initial begin
    int p;
    int i;
    int assertFails;
    clk = 1'b0;
    rstN = 1'b0;
    portReq = '0;
    busy = '0;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    for (p = 0; p < 2; p++) begin
      issued[p] = 0;
      wordLo[p] = -1;
      wordHi[p] = -1;
      lastAddr[p] = 32'h100;
    end
    for (i = 0; i < SpaceBytes; i++) begin
      refMem[i] = 8'h00;
    end
    void'($urandom(32'h8cf2_357a));
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    while ((issued[0] < AccessCount) || (issued[1] < AccessCount) || (busy != 2'b00)) begin
      for (p = 0; p < 2; p++) begin
        if (!busy[p]) begin
          if (issued[p] < AccessCount) begin
            issueAccess(p);
          end else begin
            portReq[p] = '0;
          end
        end
      end
      // Sample just ahead of the rising edge
      #4;
      for (p = 0; p < 2; p++) begin
        if (busy[p] && ready[p]) begin
          completeAccess(p);
        end
      end
      @(negedge clk);
    end

    portReq = '0;
    repeat (2) @(negedge clk);
    // Both ports idle, so both report ready
    checkValue("idle ready", 32'd3, 32'(ready));
    assertFails = DUT.uChecker.assertFails;
    $display("%0d checks, %0d errors, %0d assertion failures", checkCount, errorCount,
             assertFails);
    if ((errorCount == 0) && (assertFails == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
memTypesPkg.sv
cacheTypesPkg.sv
loadFormatter.sv
cacheL1.sv
memArbiter.sv
mainMemory.sv
memSubsystem.sv
memSubsystem_checker.sv
tbMemSubsystem.sv
